// ==== common/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

	localparam int NB_DATA   = 32;	// word width
	localparam int NB_ADDR   = 6;	// 64 instruction words
	localparam int NB_REG    = 3;	// 8 registers
	localparam int NB_CYCLES = 16;	// instruction counter width
	localparam int NB_BYTE   = 8;

	localparam int CLKS_PER_BIT = 8;	// clocks per serial bit
	localparam int NB_BIT_CNT   = $clog2(CLKS_PER_BIT);

	typedef logic [NB_DATA-1:0]    data_t;
	typedef logic [NB_ADDR-1:0]    addr_t;
	typedef logic [NB_REG-1:0]     reg_idx_t;
	typedef logic [NB_CYCLES-1:0]  cycles_t;
	typedef logic [NB_BYTE-1:0]    byte_t;
	typedef logic [NB_BIT_CNT-1:0] bit_cnt_t;

	localparam logic [5:0] OP_RTYPE  = 6'd0;
	localparam logic [5:0] OP_ADDI   = 6'd8;
	localparam logic [5:0] OP_HALT   = 6'd63;
	localparam logic [5:0] FUNCT_ADD = 6'd32;

	localparam byte_t CMD_LOAD = 8'h4c;	// 'L'
	localparam byte_t CMD_RUN  = 8'h52;	// 'R'
	localparam byte_t CMD_STEP = 8'h53;	// 'S'

	// dump is pc, count low/high, then 8 registers of 4 bytes each
	localparam int DUMP_HDR_BYTES = 3;
	localparam int DUMP_BYTES     = 35;
	localparam int NB_DUMP_IDX    = $clog2(DUMP_BYTES);

	typedef logic [NB_DUMP_IDX-1:0] dump_idx_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_BYTES,
		RUNNING,
		STEPPING,
		DUMP_SEND,
		DUMP_WAIT
	} dbg_state_t;

endpackage

`default_nettype wire

// ==== source/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
	input  logic           i_clock,
	input  logic           i_rst_n,
	input  logic           i_rx,
	output dbg_pkg::byte_t o_byte,
	output logic           o_valid
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t         state;
	logic              rx_meta;
	logic              rx_sync;
	dbg_pkg::bit_cnt_t clk_cnt;
	logic [2:0]        bit_idx;
	dbg_pkg::byte_t    shift;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			rx_meta <= 1'b1;	// line idles high
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state   <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			case (state)
			RX_IDLE: begin
				clk_cnt <= '0;
				if (!rx_sync) state <= RX_START;	// falling edge of start bit
			end
			RX_START: begin
				if (clk_cnt == dbg_pkg::bit_cnt_t'(dbg_pkg::CLKS_PER_BIT / 2 - 1)) begin
					clk_cnt <= '0;
					bit_idx <= '0;
					state   <= rx_sync ? RX_IDLE : RX_DATA;	// glitch goes back to idle
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			RX_DATA: begin
				if (clk_cnt == dbg_pkg::bit_cnt_t'(dbg_pkg::CLKS_PER_BIT - 1)) begin
					clk_cnt <= '0;
					shift   <= {rx_sync, shift[7:1]};	// lsb arrives first
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) state <= RX_STOP;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			default: begin
				if (clk_cnt == dbg_pkg::bit_cnt_t'(dbg_pkg::CLKS_PER_BIT - 1)) begin
					o_valid <= rx_sync;	// no stop bit, byte dropped
					state   <= RX_IDLE;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			endcase
		end
	end

	assign o_byte = shift;

	a_valid_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_valid |=> !o_valid);

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
	input  logic           i_clock,
	input  logic           i_rst_n,
	input  dbg_pkg::byte_t i_byte,
	input  logic           i_valid,
	output logic           o_ready,
	output logic           o_tx
);

	logic              busy;
	logic [8:0]        shift;	// data bits then stop bit
	dbg_pkg::bit_cnt_t clk_cnt;
	logic [3:0]        bit_idx;	// 0 start, 1..8 data, 9 stop

	assign o_ready = !busy;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			busy    <= 1'b0;
			o_tx    <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			if (i_valid) begin
				busy    <= 1'b1;
				o_tx    <= 1'b0;	// start bit
				clk_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (clk_cnt == dbg_pkg::bit_cnt_t'(dbg_pkg::CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;	// stop bit done
			end else begin
				o_tx    <= shift[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!busy && i_valid)
			shift <= {1'b1, i_byte};
		else if (busy && clk_cnt == dbg_pkg::bit_cnt_t'(dbg_pkg::CLKS_PER_BIT - 1))
			shift <= {1'b1, shift[8:1]};
	end

	// a waiting sender keeps its byte until it is taken
	a_hold_byte: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_valid && !o_ready) |=> (i_valid && $stable(i_byte)));

endmodule

`default_nettype wire

// ==== debug_unit/debug_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_unit (
	input  logic                i_clock,
	input  logic                i_rst_n,
	input  dbg_pkg::byte_t      i_rx_byte,
	input  logic                i_rx_valid,
	output dbg_pkg::byte_t      o_tx_byte,
	output logic                o_tx_valid,
	input  logic                i_tx_ready,
	output logic                o_inst_we,
	output dbg_pkg::addr_t      o_inst_addr,
	output dbg_pkg::data_t      o_inst_data,
	output logic                o_exec_en,
	input  logic                i_halted,
	input  dbg_pkg::addr_t      i_pc,
	input  dbg_pkg::cycles_t    i_count,
	output dbg_pkg::reg_idx_t   o_reg_sel,
	input  dbg_pkg::data_t      i_reg_data,
	output dbg_pkg::dbg_state_t o_state
);

	dbg_pkg::dbg_state_t state;
	dbg_pkg::addr_t      load_addr;
	dbg_pkg::data_t      word;
	logic [1:0]          byte_cnt;
	dbg_pkg::dump_idx_t  dump_idx;
	dbg_pkg::dump_idx_t  dump_rel;
	dbg_pkg::byte_t      dump_byte;

	assign o_state     = state;
	assign o_inst_addr = load_addr;
	assign o_inst_data = word;
	assign o_exec_en   = (state == dbg_pkg::RUNNING) || (state == dbg_pkg::STEPPING);

	// register bytes start after the pc and count header
	assign dump_rel  = dump_idx - dbg_pkg::dump_idx_t'(dbg_pkg::DUMP_HDR_BYTES);
	assign o_reg_sel = dump_rel[4:2];

	always_comb begin
		case (dump_idx)
		dbg_pkg::dump_idx_t'(0): dump_byte = dbg_pkg::byte_t'(i_pc);	// zero extended
		dbg_pkg::dump_idx_t'(1): dump_byte = i_count[7:0];
		dbg_pkg::dump_idx_t'(2): dump_byte = i_count[15:8];
		default:                 dump_byte = i_reg_data[8*dump_rel[1:0] +: 8];
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state      <= dbg_pkg::IDLE;
			load_addr  <= '0;
			byte_cnt   <= '0;
			dump_idx   <= '0;
			o_inst_we  <= 1'b0;
			o_tx_valid <= 1'b0;
		end else begin
			o_inst_we <= 1'b0;
			if (o_inst_we) load_addr <= load_addr + 1'b1;	// wraps at 64
			case (state)
			dbg_pkg::IDLE: begin
				if (i_rx_valid) begin
					case (i_rx_byte)
					dbg_pkg::CMD_LOAD: state <= dbg_pkg::LOAD_BYTES;
					dbg_pkg::CMD_RUN:  state <= dbg_pkg::RUNNING;
					dbg_pkg::CMD_STEP: state <= dbg_pkg::STEPPING;
					default:           state <= dbg_pkg::IDLE;	// unknown byte
					endcase
				end
			end
			dbg_pkg::LOAD_BYTES: begin
				if (i_rx_valid) begin
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == 2'd3) begin
						o_inst_we <= 1'b1;	// word complete
						state     <= dbg_pkg::IDLE;
					end
				end
			end
			dbg_pkg::RUNNING: begin
				if (i_halted) state <= dbg_pkg::DUMP_SEND;
			end
			dbg_pkg::STEPPING: begin
				state <= dbg_pkg::DUMP_SEND;	// one exec cycle only
			end
			dbg_pkg::DUMP_SEND: begin
				o_tx_valid <= 1'b1;
				state      <= dbg_pkg::DUMP_WAIT;
			end
			dbg_pkg::DUMP_WAIT: begin
				if (o_tx_valid && i_tx_ready) begin
					o_tx_valid <= 1'b0;
					if (dump_idx == dbg_pkg::dump_idx_t'(dbg_pkg::DUMP_BYTES - 1)) begin
						dump_idx <= '0;
						state    <= dbg_pkg::IDLE;
					end else begin
						dump_idx <= dump_idx + 1'b1;
						state    <= dbg_pkg::DUMP_SEND;
					end
				end
			end
			default: state <= dbg_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == dbg_pkg::LOAD_BYTES && i_rx_valid)
			word <= {i_rx_byte, word[31:8]};	// lsb first
		if (state == dbg_pkg::DUMP_SEND)
			o_tx_byte <= dump_byte;
	end

	// loading and executing never overlap
	a_no_exec_on_load: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!(o_exec_en && o_inst_we));

endmodule

`default_nettype wire

// ==== core/core_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_datapath (
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  logic              i_inst_we,
	input  dbg_pkg::addr_t    i_inst_addr,
	input  dbg_pkg::data_t    i_inst_data,
	input  logic              i_exec_en,
	input  dbg_pkg::reg_idx_t i_reg_sel,
	output dbg_pkg::data_t    o_reg_data,
	output dbg_pkg::addr_t    o_pc,
	output dbg_pkg::cycles_t  o_count,
	output logic              o_halted
);

	dbg_pkg::data_t    imem [2**dbg_pkg::NB_ADDR];
	dbg_pkg::data_t    regs [2**dbg_pkg::NB_REG];

	dbg_pkg::data_t    inst;
	logic [5:0]        opcode;
	logic [5:0]        funct;
	dbg_pkg::reg_idx_t rs;
	dbg_pkg::reg_idx_t rt;
	dbg_pkg::reg_idx_t rd;
	dbg_pkg::data_t    imm_ext;
	dbg_pkg::data_t    rs_val;
	dbg_pkg::data_t    rt_val;
	logic              wr_en;
	dbg_pkg::reg_idx_t wr_idx;
	dbg_pkg::data_t    wr_val;
	logic              is_halt;
	logic              step;

	always_ff @(posedge i_clock) begin
		if (i_inst_we) imem[i_inst_addr] <= i_inst_data;
	end

	// fetch and field split, only the low bits of each register field
	assign inst    = imem[o_pc];
	assign opcode  = inst[31:26];
	assign rs      = inst[23:21];
	assign rt      = inst[18:16];
	assign rd      = inst[13:11];
	assign funct   = inst[5:0];
	assign imm_ext = {{16{inst[15]}}, inst[15:0]};	// sign extended

	assign rs_val     = regs[rs];
	assign rt_val     = regs[rt];
	assign o_reg_data = regs[i_reg_sel];

	always_comb begin
		wr_en   = 1'b0;
		wr_idx  = rt;
		wr_val  = rs_val + imm_ext;
		is_halt = 1'b0;
		case (opcode)
		dbg_pkg::OP_ADDI: wr_en = 1'b1;
		dbg_pkg::OP_RTYPE: begin
			if (funct == dbg_pkg::FUNCT_ADD) begin
				wr_en  = 1'b1;
				wr_idx = rd;
				wr_val = rs_val + rt_val;
			end
		end
		dbg_pkg::OP_HALT: is_halt = 1'b1;
		default: wr_en = 1'b0;	// treated as no-op
		endcase
	end

	assign step = i_exec_en && !o_halted;	// enable has no effect once halted

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_pc     <= '0;
			o_count  <= '0;
			o_halted <= 1'b0;
			for (int i = 0; i < 2**dbg_pkg::NB_REG; i++) begin
				regs[i] <= '0;
			end
		end else if (step) begin
			o_pc    <= o_pc + 1'b1;
			o_count <= o_count + 1'b1;
			if (is_halt) o_halted <= 1'b1;
			if (wr_en && wr_idx != '0) regs[wr_idx] <= wr_val;	// r0 stays zero
		end
	end

endmodule

`default_nettype wire

// ==== source/dbg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dbg_top (
	input  logic                i_clock,
	input  logic                i_rst_n,
	input  logic                i_rx,
	output logic                o_tx,
	output dbg_pkg::dbg_state_t o_state
);

	dbg_pkg::byte_t    rx_byte;
	logic              rx_valid;
	dbg_pkg::byte_t    tx_byte;
	logic              tx_valid;
	logic              tx_ready;
	logic              inst_we;
	dbg_pkg::addr_t    inst_addr;
	dbg_pkg::data_t    inst_data;	// word to load
	logic              exec_en;
	logic              halted;
	dbg_pkg::addr_t    pc;
	dbg_pkg::cycles_t  count;
	dbg_pkg::reg_idx_t reg_sel;	// dump register select
	dbg_pkg::data_t    reg_data;

	uart_rx u_uart_rx (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_rx    (i_rx),
		.o_byte  (rx_byte),
		.o_valid (rx_valid)
	);

	uart_tx u_uart_tx (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_byte  (tx_byte),
		.i_valid (tx_valid),
		.o_ready (tx_ready),
		.o_tx    (o_tx)
	);

	debug_unit u_debug_unit (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_rx_byte   (rx_byte),
		.i_rx_valid  (rx_valid),
		.o_tx_byte   (tx_byte),
		.o_tx_valid  (tx_valid),
		.i_tx_ready  (tx_ready),
		.o_inst_we   (inst_we),
		.o_inst_addr (inst_addr),
		.o_inst_data (inst_data),
		.o_exec_en   (exec_en),
		.i_halted    (halted),
		.i_pc        (pc),
		.i_count     (count),
		.o_reg_sel   (reg_sel),
		.i_reg_data  (reg_data),
		.o_state     (o_state)
	);

	core_datapath u_core (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_inst_we   (inst_we),
		.i_inst_addr (inst_addr),
		.i_inst_data (inst_data),
		.i_exec_en   (exec_en),
		.i_reg_sel   (reg_sel),
		.o_reg_data  (reg_data),
		.o_pc        (pc),
		.o_count     (count),
		.o_halted    (halted)
	);

endmodule

`default_nettype wire

// ==== tests/uart_host_tasks.svh ====
`ifndef UART_HOST_TASKS_SVH
`define UART_HOST_TASKS_SVH

// host end of the serial link driven and sampled on the falling clock edge

task automatic hold_bit(input logic value);
	i_rx = value;
	repeat (dbg_pkg::CLKS_PER_BIT) @(negedge i_clock);
endtask

task automatic send_byte(input dbg_pkg::byte_t value);
	@(negedge i_clock);
	hold_bit(1'b0);	// start bit
	for (int i = 0; i < 8; i++) begin
		hold_bit(value[i]);	// lsb first
	end
	hold_bit(1'b1);	// stop bit
endtask

task automatic send_word(input dbg_pkg::data_t word);
	send_byte(dbg_pkg::CMD_LOAD);
	for (int k = 0; k < 4; k++) begin
		send_byte(word[8*k +: 8]);
	end
endtask

task automatic recv_byte(output dbg_pkg::byte_t value);
	@(negedge i_clock);
	while (o_tx !== 1'b0) begin
		@(negedge i_clock);	// wait for a start bit
	end
	repeat (dbg_pkg::CLKS_PER_BIT / 2) @(negedge i_clock);
	if (o_tx !== 1'b0)
		abort_run("start bit on o_tx ended too early");
	for (int i = 0; i < 8; i++) begin
		repeat (dbg_pkg::CLKS_PER_BIT) @(negedge i_clock);
		value[i] = o_tx;	// middle of the bit
	end
	repeat (dbg_pkg::CLKS_PER_BIT) @(negedge i_clock);
	if (o_tx !== 1'b1)
		abort_run("stop bit on o_tx is missing");
endtask

`endif

// ==== tests/tb_dbg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dbg_top;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	localparam int BYTE_CLKS    = 10 * dbg_pkg::CLKS_PER_BIT;
	localparam int PROG_WORDS   = 13;	// 12 alu ops then halt
	localparam int N_STEPS      = 5;
	localparam int N_UNKNOWN    = 8;
	localparam int WRAP_WORDS   = 66;
	localparam int HALT_AT      = 20;	// halt address of the wrap program
	localparam int DUMP_XFER    = 1 + dbg_pkg::DUMP_BYTES;	// command and its dump

	// serial bytes of all tests in the order idle, run, halted, step, robustness and wrap
	localparam int TOTAL_BYTES = 2 + (PROG_WORDS * 5 + DUMP_XFER) + 2 * DUMP_XFER
		+ (PROG_WORDS * 5 + N_STEPS * DUMP_XFER) + (N_UNKNOWN + 2 * DUMP_XFER + 4)
		+ (WRAP_WORDS * 5 + DUMP_XFER);
	localparam longint WATCHDOG_NS =
		longint'(TOTAL_BYTES * BYTE_CLKS * 3 + 3 * RESET_CYCLES) * CLK_PERIOD;

	logic                i_clock;
	logic                i_rst_n;
	logic                i_rx;
	logic                o_tx;
	dbg_pkg::dbg_state_t o_state;

	dbg_pkg::data_t   m_mem [2**dbg_pkg::NB_ADDR];	// reference model
	dbg_pkg::data_t   m_regs [8];
	dbg_pkg::addr_t   m_pc;
	dbg_pkg::cycles_t m_count;
	logic             m_halted;
	dbg_pkg::addr_t   m_load_addr;

	dbg_pkg::byte_t   dump [dbg_pkg::DUMP_BYTES];	// last received dump
	dbg_pkg::addr_t   d_pc;
	dbg_pkg::cycles_t d_count;
	dbg_pkg::data_t   d_regs [8];
	dbg_pkg::addr_t   prev_pc;
	dbg_pkg::cycles_t prev_count;
	dbg_pkg::data_t   prev_regs [8];

	dbg_top dut0 (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_rx    (i_rx),
		.o_tx    (o_tx),
		.o_state (o_state)
	);

	always #(CLK_PERIOD / 2) i_clock = ~i_clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first failure");
	endtask

	`include "uart_host_tasks.svh"

	task automatic check_addr(input string name, input dbg_pkg::addr_t exp,
		input dbg_pkg::addr_t act);
		if (act !== exp)
			abort_run($sformatf("error: %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_count(input string name, input dbg_pkg::cycles_t exp,
		input dbg_pkg::cycles_t act);
		if (act !== exp)
			abort_run($sformatf("error: %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_data(input string name, input dbg_pkg::data_t exp,
		input dbg_pkg::data_t act);
		if (act !== exp)
			abort_run($sformatf("error: %s expected %08h actual %08h", name, exp, act));
	endtask

	task automatic check_state(input string name, input dbg_pkg::dbg_state_t exp,
		input dbg_pkg::dbg_state_t act);
		if (act !== exp)
			abort_run($sformatf("error: %s expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic model_reset();
		m_pc        = '0;
		m_count     = '0;
		m_halted    = 1'b0;
		m_load_addr = '0;
		for (int r = 0; r < 8; r++) begin
			m_regs[r] = '0;
		end
	endtask

	task automatic model_step();
		dbg_pkg::data_t inst;
		dbg_pkg::reg_idx_t s;
		dbg_pkg::reg_idx_t t;
		dbg_pkg::reg_idx_t d;
		if (m_halted)
			return;	// halted core ignores enables
		inst = m_mem[m_pc];
		s    = inst[23:21];	// low three bits of each field
		t    = inst[18:16];
		d    = inst[13:11];
		if (inst[31:26] == dbg_pkg::OP_ADDI && t != 0)
			m_regs[t] = m_regs[s] + {{16{inst[15]}}, inst[15:0]};
		else if (inst[31:26] == dbg_pkg::OP_RTYPE && inst[5:0] == dbg_pkg::FUNCT_ADD && d != 0)
			m_regs[d] = m_regs[s] + m_regs[t];
		else if (inst[31:26] == dbg_pkg::OP_HALT)
			m_halted = 1'b1;
		m_pc    = m_pc + 1'b1;
		m_count = m_count + 1'b1;
	endtask

	task automatic model_run();
		int guard;
		guard = 0;
		while (!m_halted && guard < 4096) begin
			model_step();
			guard++;
		end
	endtask

	function automatic dbg_pkg::data_t random_alu_inst();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		rs = 5'($urandom);
		rt = 5'($urandom);
		rd = 5'($urandom);
		if ($urandom % 2 == 0)
			return {dbg_pkg::OP_ADDI, rs, rt, 16'($urandom)};
		return {dbg_pkg::OP_RTYPE, rs, rt, rd, 5'($urandom), dbg_pkg::FUNCT_ADD};
	endfunction

	function automatic dbg_pkg::data_t make_halt();
		return {dbg_pkg::OP_HALT, 26'($urandom)};	// only the opcode matters
	endfunction

	function automatic dbg_pkg::byte_t unknown_byte();
		dbg_pkg::byte_t b;
		b = 8'($urandom);
		while (b == dbg_pkg::CMD_LOAD || b == dbg_pkg::CMD_RUN || b == dbg_pkg::CMD_STEP)
			b = 8'($urandom);
		return b;
	endfunction

	task automatic load_word(input dbg_pkg::data_t word);
		send_word(word);
		m_mem[m_load_addr] = word;
		m_load_addr        = m_load_addr + 1'b1;	// wraps like the load pointer
	endtask

	task automatic load_random_program();
		for (int k = 0; k < PROG_WORDS - 1; k++) begin
			load_word(random_alu_inst());
		end
		load_word(make_halt());
	endtask

	task automatic apply_reset();
		@(negedge i_clock);
		i_rst_n = 1'b0;
		i_rx    = 1'b1;
		repeat (RESET_CYCLES) @(negedge i_clock);
		i_rst_n = 1'b1;
		model_reset();
	endtask

	task automatic recv_dump();
		dbg_pkg::byte_t b;
		for (int i = 0; i < dbg_pkg::DUMP_BYTES; i++) begin
			recv_byte(b);
			dump[i] = b;
		end
		repeat (dbg_pkg::CLKS_PER_BIT / 2) @(negedge i_clock);	// rest of the last stop bit
		d_pc    = dump[0][5:0];
		d_count = {dump[2], dump[1]};
		for (int r = 0; r < 8; r++) begin
			d_regs[r] = {dump[4*r+6], dump[4*r+5], dump[4*r+4], dump[4*r+3]};
		end
	endtask

	// command and dump overlap in time so listen while sending
	task automatic run_command(input dbg_pkg::byte_t cmd);
		fork
			send_byte(cmd);
			recv_dump();
		join
	endtask

	task automatic check_dump(input string name);
		if (dump[0][7:6] != 2'b00)
			abort_run($sformatf("%s: the pc byte is not zero extended", name));
		check_addr({name, " pc"}, m_pc, d_pc);
		check_count({name, " count"}, m_count, d_count);
		for (int r = 0; r < 8; r++) begin
			check_data($sformatf("%s r%0d", name, r), m_regs[r], d_regs[r]);
		end
	endtask

	task automatic save_dump();
		prev_pc    = d_pc;
		prev_count = d_count;
		for (int r = 0; r < 8; r++) begin
			prev_regs[r] = d_regs[r];
		end
	endtask

	task automatic check_unchanged(input string name);
		check_addr({name, " pc"}, prev_pc, d_pc);
		check_count({name, " count"}, prev_count, d_count);
		for (int r = 0; r < 8; r++) begin
			check_data($sformatf("%s r%0d", name, r), prev_regs[r], d_regs[r]);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run("timeout: the tests did not finish in the expected time");
	end

	initial begin
		i_clock = 1'b0;
		i_rst_n = 1'b0;
		i_rx    = 1'b1;	// serial line idles high
		void'($urandom(77));
		apply_reset();

		check_state("reset state", dbg_pkg::IDLE, o_state);
		repeat (100) begin
			@(negedge i_clock);
			if (o_tx !== 1'b1)
				abort_run("o_tx left the idle level after reset");
		end

		load_random_program();
		run_command(dbg_pkg::CMD_RUN);
		model_run();
		check_dump("load and run");
		check_addr("run pc", dbg_pkg::addr_t'(PROG_WORDS), d_pc);
		check_count("run count", dbg_pkg::cycles_t'(PROG_WORDS), d_count);
		check_data("run r0", '0, d_regs[0]);
		save_dump();

		run_command(dbg_pkg::CMD_STEP);	// core already halted
		check_dump("step when halted");
		check_unchanged("step when halted");
		run_command(dbg_pkg::CMD_RUN);
		check_dump("run when halted");
		check_unchanged("run when halted");

		apply_reset();
		load_random_program();
		prev_pc    = '0;
		prev_count = '0;
		for (int s = 0; s < N_STEPS; s++) begin
			run_command(dbg_pkg::CMD_STEP);
			model_step();
			check_dump($sformatf("step %0d", s));
			check_addr("step pc advance", prev_pc + 1'b1, d_pc);
			check_count("step count advance", prev_count + 1'b1, d_count);
			save_dump();
		end

		for (int u = 0; u < N_UNKNOWN; u++) begin
			send_byte(unknown_byte());
			repeat (2) @(negedge i_clock);
			check_state("unknown byte", dbg_pkg::IDLE, o_state);
		end
		fork
			begin
				send_byte(dbg_pkg::CMD_STEP);
				repeat (3 * BYTE_CLKS) @(negedge i_clock);
				send_byte(dbg_pkg::CMD_RUN);	// arrives while the dump is going out
			end
			recv_dump();
		join
		model_step();
		check_dump("step with command mid-dump");
		repeat (2) @(negedge i_clock);
		check_state("after mid-dump command", dbg_pkg::IDLE, o_state);
		run_command(dbg_pkg::CMD_RUN);
		model_run();
		check_dump("run after robustness");

		apply_reset();
		for (int w = 0; w < WRAP_WORDS; w++) begin
			if (w < 2 || w == HALT_AT)
				load_word(make_halt());	// first two get overwritten
			else
				load_word(random_alu_inst());
		end
		run_command(dbg_pkg::CMD_RUN);
		model_run();
		check_dump("load wrap");
		check_addr("wrap pc", dbg_pkg::addr_t'(HALT_AT + 1), d_pc);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+tests
common/dbg_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
debug_unit/debug_unit.sv
core/core_datapath.sv
source/dbg_top.sv
tests/tb_dbg_top.sv

// ==== Bender.yml ====
package:
  name: dbg_top

sources:
  - files:
      - common/dbg_pkg.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - debug_unit/debug_unit.sv
      - core/core_datapath.sv
      - source/dbg_top.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_dbg_top.sv
